// ==== bench/shiftArrayTb.sv ====
`default_nettype none

`include "shift_settings.svh"

module shiftArrayTb
	import shiftPkg::*;
();

	localparam int NumVectors = 28; // 4 modes x 7 amounts
	localparam int TimeoutCycles = NumVectors * 30 + 200;

	typedef struct packed {
		logic [1:0] lane;
		shiftMode_t mode;
		logic [`SHIFT_AMT_WIDTH-1:0] amount;
		logic [`SHIFT_WIDTH-1:0] operand;
		logic [`SHIFT_WIDTH-1:0] expected;
	} vector_t;

	logic clk = 1'b0;
	logic rst;
	logic psel;
	logic penable;
	logic pwrite;
	logic [6:0] paddr;
	logic [31:0] pwdata;
	logic [31:0] prdata;
	logic pready;
	logic pslverr;

	vector_t vectors [NumVectors];
	logic [3:0] amtList [7] = '{4'd0, 4'd1, 4'd3, 4'd4, 4'd7, 4'd12, 4'd15};
	int errors = 0;
	int testsRun = 0;
	int testsFailed = 0;
	int cycles = 0;

	shiftArray shiftArray_i (
		.clk(clk), .rst(rst),
		.psel(psel), .penable(penable), .pwrite(pwrite),
		.paddr(paddr), .pwdata(pwdata),
		.prdata(prdata), .pready(pready), .pslverr(pslverr)
	);

	always #20 clk = ~clk;

	always @(posedge clk) begin
		cycles <= cycles + 1;
		if (cycles >= TimeoutCycles) begin
			$display("Run timed out after %0d cycles", cycles);
			$display("FAIL: see errors above");
			$finish;
		end
	end

	// Bit by bit from the mode definitions
	function automatic logic [15:0] refShift(input shiftMode_t mode, input logic [3:0] amt,
		input logic [15:0] op);
		logic [15:0] res;
		int src;
		for (int i = 0; i < 16; i++) begin
			src = i + int'(amt);
			case (mode)
				modeSll: res[i] = (i >= int'(amt)) ? op[i - int'(amt)] : 1'b0;
				modeSra: res[i] = (src < 16) ? op[src] : op[15];
				modeRor: res[i] = op[src % 16];
				default: res[i] = op[i];
			endcase
		end
		return res;
	endfunction

	task automatic compareWord(input logic [31:0] got, input logic [31:0] exp, input string what);
		if (got !== exp) begin
			$display("CHECK FAILED at %0t: %s, got %h expected %h", $time, what, got, exp);
			errors++;
		end
	endtask

	task automatic reportTest(input string name, input int errBefore);
		testsRun++;
		if (errors == errBefore) begin
			$display("Test %s: ok", name);
		end else begin
			testsFailed++;
			$display("Test %s: FAILED", name);
		end
	endtask

	// Starts and ends on a falling edge
	task automatic apbAccess(input logic write, input logic [6:0] addr, input logic [31:0] wdata,
		output logic [31:0] rdOut, output logic err);
		psel = 1'b1;
		penable = 1'b0;
		pwrite = write;
		paddr = addr;
		pwdata = wdata;
		@(negedge clk);
		penable = 1'b1;
		#5;
		compareWord(32'(pready), 32'h1, "pready in access phase");
		rdOut = prdata;
		err = pslverr;
		@(negedge clk);
		psel = 1'b0;
		penable = 1'b0;
		pwrite = 1'b0;
	endtask

	task automatic writeCmd(input logic [1:0] lane, input shiftMode_t mode, input logic [3:0] amt,
		input logic [15:0] op);
		logic [31:0] rd;
		logic err;
		apbAccess(1'b1, 7'(lane * `SHIFT_LANE_STRIDE), {10'h0, mode, amt, op}, rd, err);
		compareWord(32'(err), 32'h0, "pslverr on command write");
	endtask

	task automatic readStatus(output logic [31:0] st);
		logic err;
		apbAccess(1'b0, `SHIFT_STATUS_ADDR, 32'h0, st, err);
		compareWord(32'(err), 32'h0, "pslverr on status read");
	endtask

	task automatic readResult(input logic [1:0] lane, output logic [31:0] word);
		logic err;
		apbAccess(1'b0, 7'(lane * `SHIFT_LANE_STRIDE + `SHIFT_RESULT_OFFSET), 32'h0, word, err);
		compareWord(32'(err), 32'h0, "pslverr on result read");
	endtask

	task automatic waitReady(input logic [1:0] lane);
		logic [31:0] st;
		st = '0;
		while (st[lane] !== 1'b1) begin
			readStatus(st);
		end
	endtask

	initial begin
		int unsigned seed;
		int k;
		int errBefore;
		logic [31:0] st;
		logic [31:0] word;
		logic [31:0] rd;
		logic err;
		logic [15:0] b2bOp [4];
		logic [6:0] errAddr [4];
		logic [3:0] errWrite;

		seed = $urandom(3480);
		rst = 1'b1;
		psel = 1'b0;
		penable = 1'b0;
		pwrite = 1'b0;
		paddr = '0;
		pwdata = '0;

		for (int m = 0; m < 4; m++) begin
			for (int i = 0; i < 7; i++) begin
				k = m * 7 + i;
				vectors[k].lane = 2'(k % 4); // Seven entries per mode cover all lanes
				vectors[k].mode = shiftMode_t'(2'(m));
				vectors[k].amount = amtList[i];
				vectors[k].operand = (i % 2 == 0) ? (16'h8000 | 16'($urandom)) : 16'($urandom);
				vectors[k].expected = refShift(vectors[k].mode, vectors[k].amount,
					vectors[k].operand);
			end
		end

		repeat (10) @(negedge clk);
		rst = 1'b0;

		errBefore = errors;
		compareWord(32'(pslverr), 32'h0, "pslverr after reset");
		readStatus(st);
		compareWord(st, 32'h0, "status after reset");
		reportTest("after reset", errBefore);

		for (int v = 0; v < NumVectors; v++) begin
			errBefore = errors;
			writeCmd(vectors[v].lane, vectors[v].mode, vectors[v].amount, vectors[v].operand);
			waitReady(vectors[v].lane);
			readResult(vectors[v].lane, word);
			compareWord(word, {15'h0, 1'b1, vectors[v].expected}, "result word");
			readStatus(st);
			compareWord(st, 32'h0, "status after result read");
			reportTest($sformatf("lane %0d %s amt %0d op %h", vectors[v].lane,
				vectors[v].mode.name(), vectors[v].amount, vectors[v].operand), errBefore);
		end

		errBefore = errors;
		for (int l = 0; l < 4; l++) begin
			b2bOp[l] = 16'($urandom);
			writeCmd(2'(l), modeRor, 4'(l * 3 + 1), b2bOp[l]);
		end
		st = '0;
		while (st[3:0] !== 4'hF) begin
			readStatus(st);
		end
		for (int l = 0; l < 4; l++) begin
			readResult(2'(l), word);
			compareWord(word, {15'h0, 1'b1, refShift(modeRor, 4'(l * 3 + 1), b2bOp[l])},
				"back-to-back result");
			readStatus(st);
			compareWord(st, {28'h0, 4'hF << (l + 1)}, "status after back-to-back read");
		end
		reportTest("back-to-back lanes", errBefore);

		errBefore = errors;
		writeCmd(2'd2, modeSll, 4'd1, 16'h1357);
		writeCmd(2'd2, modeSra, 4'd5, 16'hC0DE);
		waitReady(2'd2);
		repeat (4) @(negedge clk); // Second result is in by now
		readStatus(st);
		compareWord(st, 32'h4, "status after overrun");
		readResult(2'd2, word);
		compareWord(word, {15'h0, 1'b1, refShift(modeSra, 4'd5, 16'hC0DE)}, "overrun result");
		readStatus(st);
		compareWord(st, 32'h0, "status after overrun read");
		reportTest("overrun", errBefore);

		errBefore = errors;
		errAddr = '{7'h60, `SHIFT_STATUS_ADDR, 7'h0C, 7'h18};
		errWrite = 4'b0110; // Unmapped read, status write, result write, command read
		writeCmd(2'd0, modePass, 4'd9, 16'h1234);
		waitReady(2'd0);
		for (int i = 0; i < 4; i++) begin
			apbAccess(errWrite[3 - i], errAddr[i], 32'h0030_FFFF, rd, err);
			compareWord(32'(err), 32'h1, $sformatf("pslverr for address %h", errAddr[i]));
			readStatus(st);
			compareWord(st, 32'h1, "status after error access");
		end
		readResult(2'd0, word);
		compareWord(word, 32'h0001_1234, "result after error accesses");
		reportTest("error accesses", errBefore);

		$display("Tests run %0d, tests failed %0d, check errors %0d", testsRun, testsFailed,
			errors);
		if (errors == 0) begin
			$display("PASS: all tests");
		end else begin
			$display("FAIL: see errors above");
		end
		$finish;
	end

endmodule

`default_nettype wire

// ==== hdl/apbCmdDecoder.sv ====
`default_nettype none

`include "shift_settings.svh"

module apbCmdDecoder
	import shiftPkg::*;
(
	input wire logic clk,
	input wire logic rst,
	input wire logic psel,
	input wire logic penable,
	input wire logic pwrite,
	input wire logic [6:0] paddr,
	input wire logic [31:0] pwdata,
	input wire logic [31:0] rdata,
	output logic [31:0] prdata,
	output logic pready,
	output logic pslverr,
	output logic [`SHIFT_LANES-1:0] issue,
	output shiftCmd_t cmd [`SHIFT_LANES],
	output apbRead_t rdSel
);

	logic access;
	logic laneHit;
	logic statusHit;
	logic resultReg; // Low selects the command register
	logic [1:0] laneIdx;
	logic wrValid;
	logic rdResultValid;
	logic rdStatusValid;
	logic decodeErr;

	assign access = psel && penable;
	assign pready = access; // Lanes never stall

	// Lane registers sit at lane * 8 + {0, 4}
	assign laneHit = (paddr[6:5] == 2'b00) && (paddr[1:0] == 2'b00);
	assign statusHit = (paddr == `SHIFT_STATUS_ADDR);
	assign resultReg = paddr[2];
	assign laneIdx = paddr[4:3];

	assign wrValid = pwrite && laneHit && !resultReg;
	assign rdResultValid = !pwrite && laneHit && resultReg;
	assign rdStatusValid = !pwrite && statusHit;
	assign decodeErr = !(wrValid || rdResultValid || rdStatusValid);

	always_comb begin
		for (int i = 0; i < `SHIFT_LANES; i++) begin
			issue[i] = access && wrValid && (laneIdx == 2'(i));
			cmd[i].mode = shiftMode_t'(pwdata[21:20]);
			cmd[i].amount = pwdata[19:16];
			cmd[i].operand = pwdata[15:0];
		end
	end

	assign rdSel.rdResult = access && rdResultValid;
	assign rdSel.rdStatus = access && rdStatusValid;
	assign rdSel.lane = laneIdx;

	assign prdata = (rdSel.rdResult || rdSel.rdStatus) ? rdata : 32'h0;

	// Error decided in setup and shown in the access phase
	always_ff @(posedge clk) begin
		if (rst) begin
			pslverr <= 1'b0;
		end else begin
			pslverr <= psel && !penable && decodeErr;
		end
	end

	// Issue only in an access phase that follows an error-free setup phase
	issueInAccess: assert property (@(posedge clk) disable iff (rst)
		(issue != '0) |-> ($onehot0(issue) && $past(psel && !penable) && !pslverr));

endmodule

`default_nettype wire

// ==== hdl/resultCollector.sv ====
`default_nettype none

`include "shift_settings.svh"

module resultCollector
	import shiftPkg::*;
(
	input wire logic clk,
	input wire logic rst,
	input wire laneResult_t laneRes [`SHIFT_LANES],
	input wire apbRead_t rdSel,
	output logic [31:0] rdata
);

	logic [`SHIFT_WIDTH-1:0] dataQ [`SHIFT_LANES];
	logic [`SHIFT_LANES-1:0] readyQ;
	logic [31:0] statusWord;
	logic [31:0] resultWord;

	// Last result per lane, overrun simply overwrites
	always_ff @(posedge clk) begin
		for (int i = 0; i < `SHIFT_LANES; i++) begin
			if (laneRes[i].valid) begin
				dataQ[i] <= laneRes[i].data;
			end
		end
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			readyQ <= '0;
		end else begin
			for (int i = 0; i < `SHIFT_LANES; i++) begin
				if (laneRes[i].valid) begin
					readyQ[i] <= 1'b1; // New result wins over a read
				end else if (rdSel.rdResult && (rdSel.lane == 2'(i))) begin
					readyQ[i] <= 1'b0;
				end
			end
		end
	end

	assign statusWord = {{(32-`SHIFT_LANES){1'b0}}, readyQ};
	assign resultWord = {{(31-`SHIFT_WIDTH){1'b0}}, readyQ[rdSel.lane], dataQ[rdSel.lane]};

	always_comb begin
		if (rdSel.rdResult) begin
			rdata = resultWord;
		end else if (rdSel.rdStatus) begin
			rdata = statusWord;
		end else begin
			rdata = 32'h0;
		end
	end

	oneReadKind: assert property (@(posedge clk) disable iff (rst)
		!(rdSel.rdResult && rdSel.rdStatus));

endmodule

`default_nettype wire

// ==== hdl/shiftArray.sv ====
`default_nettype none

`include "shift_settings.svh"

module shiftArray
	import shiftPkg::*;
(
	input wire logic clk,
	input wire logic rst,
	input wire logic psel,
	input wire logic penable,
	input wire logic pwrite,
	input wire logic [6:0] paddr,
	input wire logic [31:0] pwdata,
	output logic [31:0] prdata,
	output logic pready,
	output logic pslverr
);

	logic [`SHIFT_LANES-1:0] issue;
	shiftCmd_t cmd [`SHIFT_LANES];
	laneResult_t laneRes [`SHIFT_LANES];
	apbRead_t rdSel;
	logic [31:0] rdata;

	apbCmdDecoder apbCmdDecoder_i (
		.clk(clk), .rst(rst),
		.psel(psel), .penable(penable), .pwrite(pwrite),
		.paddr(paddr), .pwdata(pwdata), .rdata(rdata),
		.prdata(prdata), .pready(pready), .pslverr(pslverr),
		.issue(issue), .cmd(cmd), .rdSel(rdSel)
	);

	for (genvar g = 0; g < `SHIFT_LANES; g++) begin : genLane
		shiftLane shiftLane_i (
			.clk(clk), .rst(rst),
			.issue(issue[g]), .cmd(cmd[g]),
			.result(laneRes[g])
		);
	end

	resultCollector resultCollector_i (
		.clk(clk), .rst(rst),
		.laneRes(laneRes), .rdSel(rdSel),
		.rdata(rdata)
	);

endmodule

`default_nettype wire

// ==== hdl/shiftLane.sv ====
`default_nettype none

`include "shift_settings.svh"

module shiftLane
	import shiftPkg::*;
(
	input wire logic clk,
	input wire logic rst,
	input wire logic issue,
	input wire shiftCmd_t cmd,
	output laneResult_t result
);

	logic s1Valid;
	shiftMode_t s1Mode;
	logic [1:0] s1AmtHi;
	logic [`SHIFT_WIDTH-1:0] s1Data;
	logic s2Valid;
	logic [`SHIFT_WIDTH-1:0] s2Data;

	// One shift step, used with amt[1:0] first and amt[3:2] * 4 second
	function automatic logic [`SHIFT_WIDTH-1:0] shiftStep(
		input logic [`SHIFT_WIDTH-1:0] din,
		input shiftMode_t mode,
		input logic [`SHIFT_AMT_WIDTH-1:0] amt
	);
		logic [2*`SHIFT_WIDTH-1:0] doubled;
		logic [`SHIFT_WIDTH-1:0] res;
		doubled = {din, din} >> amt;
		case (mode)
			modeSll: res = din << amt;
			modeSra: res = $signed(din) >>> amt; // Sign carried from stage 1
			modeRor: res = doubled[`SHIFT_WIDTH-1:0];
			default: res = din;
		endcase
		return res;
	endfunction

	// Stage 1, fine shift by 0..3
	always_ff @(posedge clk) begin
		if (rst) begin
			s1Valid <= 1'b0;
		end else begin
			s1Valid <= issue;
		end
	end

	always_ff @(posedge clk) begin
		if (issue) begin
			s1Data <= shiftStep(cmd.operand, cmd.mode, {2'b00, cmd.amount[1:0]});
			s1Mode <= cmd.mode;
			s1AmtHi <= cmd.amount[3:2];
		end
	end

	// Stage 2, coarse shift by 0, 4, 8 or 12
	always_ff @(posedge clk) begin
		if (rst) begin
			s2Valid <= 1'b0;
		end else begin
			s2Valid <= s1Valid;
		end
	end

	always_ff @(posedge clk) begin
		if (s1Valid) begin
			s2Data <= shiftStep(s1Data, s1Mode, {s1AmtHi, 2'b00});
		end
	end

	assign result.valid = s2Valid;
	assign result.data = s2Data;

	// Identity commands must come out untouched after both stages
	identityThrough: assert property (@(posedge clk) disable iff (rst)
		(issue && ((cmd.mode == modePass) || (cmd.amount == '0)))
		|-> ##2 (result.valid && (result.data == $past(cmd.operand, 2))));

endmodule

`default_nettype wire

// ==== hdl/shiftPkg.sv ====
`default_nettype none

`include "shift_settings.svh"

package shiftPkg;

	// 00 sll, 01 sra, 10 ror, 11 pass
	typedef enum logic [1:0] {
		modeSll  = 2'b00,
		modeSra  = 2'b01,
		modeRor  = 2'b10,
		modePass = 2'b11
	} shiftMode_t;

	// Same bit layout as the APB command word
	typedef struct packed {
		shiftMode_t mode; // Bits 21:20
		logic [`SHIFT_AMT_WIDTH-1:0] amount; // Bits 19:16
		logic [`SHIFT_WIDTH-1:0] operand; // Bits 15:0
	} shiftCmd_t;

	typedef struct packed {
		logic valid; // One-cycle pulse
		logic [`SHIFT_WIDTH-1:0] data;
	} laneResult_t;

	typedef struct packed {
		logic rdResult;
		logic rdStatus;
		logic [1:0] lane;
	} apbRead_t;

endpackage

`default_nettype wire

// ==== hdl/shift_settings.svh ====
`ifndef SHIFT_SETTINGS_SVH
`define SHIFT_SETTINGS_SVH

// Datapath sizes
`define SHIFT_WIDTH 16
`define SHIFT_AMT_WIDTH 4
`define SHIFT_LANES 4

// APB register map
`define SHIFT_STATUS_ADDR 7'h40
`define SHIFT_LANE_STRIDE 8
`define SHIFT_RESULT_OFFSET 4

`endif

// ==== run.sh ====
#!/usr/bin/env bash
# Builds the testbench with Verilator, runs it and checks the log for failure
set -u
cd "$(dirname "$0")"

BUILD_LOG=build.log
SIM_LOG=sim.log

verilator --binary --timing --assert --timescale 1ns/1ns \
	--top-module shiftArrayTb -Mdir obj_dir -o simShiftArray \
	-f shiftArray.f > "$BUILD_LOG" 2>&1 \
	|| { cat "$BUILD_LOG"; echo "Build failed"; exit 1; }

./obj_dir/simShiftArray > "$SIM_LOG" 2>&1 \
	|| { cat "$SIM_LOG"; echo "Simulation exited with an error"; exit 1; }

cat "$SIM_LOG"
grep -q "FAIL: see errors above" "$SIM_LOG" \
	&& { echo "Simulation reported failure"; exit 1; } \
	|| { echo "Simulation finished without failure"; exit 0; }

// ==== shiftArray.f ====
+incdir+hdl
hdl/shiftPkg.sv
hdl/apbCmdDecoder.sv
hdl/shiftLane.sv
hdl/resultCollector.sv
hdl/shiftArray.sv
bench/shiftArrayTb.sv
